/* logic/mips_isa_pkg.sv */
package mips_isa_pkg;

    // data and address words
    typedef logic [31:0] word_t;

    // raw 16-bit immediate from the decode stage
    typedef logic [15:0] imm_t;

    // load/store operations the execute stage handles
    typedef enum logic [3:0] {
        MEM_LB  = 4'd0,
        MEM_LBU = 4'd1,
        MEM_LH  = 4'd2,
        MEM_LHU = 4'd3,
        MEM_LW  = 4'd4,
        MEM_SB  = 4'd5,
        MEM_SH  = 4'd6,
        MEM_SW  = 4'd7,
        MEM_SWL = 4'd8,
        MEM_SWR = 4'd9
    } mem_op_t;

    // cp0 exception code field
    typedef logic [4:0] exc_code_t;

    // address error on load or fetch
    localparam exc_code_t EXC_ADEL = 5'd4;
    // address error on store
    localparam exc_code_t EXC_ADES = 5'd5;

    // stores write memory, everything else reads it
    function automatic logic op_is_store(input mem_op_t op);
        logic store;
        case (op)
            MEM_SB,
            MEM_SH,
            MEM_SW,
            MEM_SWL,
            MEM_SWR: store = 1'b1;
            default: store = 1'b0;
        endcase
        return store;
    endfunction

endpackage

/* logic/mem_bus_pkg.sv */
package mem_bus_pkg;

    // one strobe bit per byte lane
    typedef logic [3:0] strb_t;

    // sram access size
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // request queue between execute and the issuer
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

endpackage

/* logic/exe_addr_stage.sv */
`timescale 1ns/1ps

module exe_addr_stage
    import mips_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // from decode
    input  logic      ds_valid,
    input  mem_op_t   ds_mem_op,
    input  word_t     ds_rs_value,
    input  word_t     ds_rt_value,
    input  imm_t      ds_imm,
    output logic      es_allowin,
    // to request queue
    input  logic      full,
    output logic      push,
    output mem_op_t   push_op,
    output word_t     push_addr,
    output word_t     push_wdata,
    output strb_t     push_wstrb,
    output size_t     push_size,
    // exception report
    output logic      exc_valid,
    output exc_code_t exc_code,
    output word_t     exc_bad_vaddr
);

    logic       es_valid;
    mem_op_t    es_mem_op;
    word_t      es_rs_value;
    word_t      es_rt_value;
    imm_t       es_imm;
    logic       es_ready_go;
    word_t      addr;
    logic [1:0] offset;
    logic       fault;
    word_t      store_data;
    strb_t      store_strb;
    size_t      size;

    // faults leave at once, requests wait for queue space
    assign es_ready_go = fault || !full;
    assign es_allowin  = !es_valid || es_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) begin
            es_mem_op   <= ds_mem_op;
            es_rs_value <= ds_rs_value;
            es_rt_value <= ds_rt_value;
            es_imm      <= ds_imm;
        end
    end

    assign addr   = es_rs_value + {{16{es_imm[15]}}, es_imm};
    assign offset = addr[1:0];

    // alignment check
    always_comb begin
        case (es_mem_op)
            MEM_LH,
            MEM_LHU,
            MEM_SH:  fault = offset[0];
            MEM_LW,
            MEM_SW:  fault = (offset != 2'b00);
            default: fault = 1'b0;
        endcase
    end

    // store lane placement, ~offset is 3 - offset
    always_comb begin
        case (es_mem_op)
            MEM_SB: begin
                store_data = {4{es_rt_value[7:0]}};
                store_strb = 4'b0001 << offset;
            end
            MEM_SH: begin
                store_data = {2{es_rt_value[15:0]}};
                store_strb = offset[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: begin
                store_data = es_rt_value;
                store_strb = 4'b1111;
            end
            MEM_SWL: begin
                store_data = es_rt_value >> {~offset, 3'b000};
                store_strb = 4'b1111 >> ~offset;
            end
            MEM_SWR: begin
                store_data = es_rt_value << {offset, 3'b000};
                store_strb = 4'b1111 << offset;
            end
            default: begin
                store_data = es_rt_value;
                store_strb = 4'b0000;
            end
        endcase
    end

    always_comb begin
        case (es_mem_op)
            MEM_LB, MEM_LBU, MEM_SB: size = SIZE_BYTE;
            MEM_LH, MEM_LHU, MEM_SH: size = SIZE_HALF;
            default:                 size = SIZE_WORD;
        endcase
    end

    assign push       = es_valid && !fault && !full;
    assign push_op    = es_mem_op;
    assign push_addr  = addr;
    assign push_wdata = store_data;
    assign push_wstrb = store_strb;
    assign push_size  = size;

    assign exc_valid     = es_valid && fault;
    assign exc_code      = op_is_store(es_mem_op) ? EXC_ADES : EXC_ADEL;
    assign exc_bad_vaddr = addr;

endmodule

/* logic/mem_req_queue.sv */
`timescale 1ns/1ps

module mem_req_queue
    import mips_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    push,
    input  mem_op_t push_op,
    input  word_t   push_addr,
    input  word_t   push_wdata,
    input  strb_t   push_wstrb,
    input  size_t   push_size,
    input  logic    pop,
    output logic    full,
    output logic    empty,
    output mem_op_t head_op,
    output word_t   head_addr,
    output word_t   head_wdata,
    output strb_t   head_wstrb,
    output size_t   head_size
);

    mem_op_t op_mem    [QUEUE_DEPTH];
    word_t   addr_mem  [QUEUE_DEPTH];
    word_t   wdata_mem [QUEUE_DEPTH];
    strb_t   wstrb_mem [QUEUE_DEPTH];
    size_t   size_mem  [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;

    // pointers wrap on their own width
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]    <= push_op;
            addr_mem[wr_ptr]  <= push_addr;
            wdata_mem[wr_ptr] <= push_wdata;
            wstrb_mem[wr_ptr] <= push_wstrb;
            size_mem[wr_ptr]  <= push_size;
        end
    end

    assign full  = (count == (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
    assign empty = (count == '0);

    assign head_op    = op_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];
    assign head_wdata = wdata_mem[rd_ptr];
    assign head_wstrb = wstrb_mem[rd_ptr];
    assign head_size  = size_mem[rd_ptr];

endmodule

/* logic/mem_req_issuer.sv */
`timescale 1ns/1ps

module mem_req_issuer
    import mips_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    // queue head
    input  logic    empty,
    input  mem_op_t head_op,
    input  word_t   head_addr,
    input  word_t   head_wdata,
    input  strb_t   head_wstrb,
    input  size_t   head_size,
    output logic    pop,
    // data sram request port
    output logic    data_sram_en,
    output logic    data_sram_wr,
    output size_t   data_sram_size,
    output strb_t   data_sram_wstrb,
    output word_t   data_sram_addr,
    output word_t   data_sram_wdata,
    input  logic    data_sram_addr_ok
);

    logic done;

    // address handshake of the current request
    assign done = data_sram_en && data_sram_addr_ok;

    // take the next head when idle or as the current one completes
    assign pop = !empty && (!data_sram_en || done);

    always_ff @(posedge clk) begin
        if (reset) begin
            data_sram_en <= 1'b0;
        end else if (pop) begin
            data_sram_en <= 1'b1;
        end else if (done) begin
            data_sram_en <= 1'b0;
        end
    end

    // fields only change on pop so they hold while waiting for addr_ok
    always_ff @(posedge clk) begin
        if (pop) begin
            data_sram_wr    <= op_is_store(head_op);
            data_sram_size  <= head_size;
            data_sram_wstrb <= head_wstrb;
            data_sram_addr  <= head_addr;
            data_sram_wdata <= head_wdata;
        end
    end

endmodule

/* logic/exe_mem_top.sv */
`timescale 1ns/1ps

module exe_mem_top
    import mips_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // decode side
    input  logic      ds_valid,
    input  mem_op_t   ds_mem_op,
    input  word_t     ds_rs_value,
    input  word_t     ds_rt_value,
    input  imm_t      ds_imm,
    output logic      es_allowin,
    // data sram
    output logic      data_sram_en,
    output logic      data_sram_wr,
    output size_t     data_sram_size,
    output strb_t     data_sram_wstrb,
    output word_t     data_sram_addr,
    output word_t     data_sram_wdata,
    input  logic      data_sram_addr_ok,
    // exceptions
    output logic      exc_valid,
    output exc_code_t exc_code,
    output word_t     exc_bad_vaddr
);

    logic    push;
    mem_op_t push_op;
    word_t   push_addr;
    word_t   push_wdata;
    strb_t   push_wstrb;
    size_t   push_size;
    logic    full;
    logic    empty;
    logic    pop;
    mem_op_t head_op;
    word_t   head_addr;
    word_t   head_wdata;
    strb_t   head_wstrb;
    size_t   head_size;

    exe_addr_stage exe_addr_stage_inst (
        .clk           (clk),
        .reset         (reset),
        .ds_valid      (ds_valid),
        .ds_mem_op     (ds_mem_op),
        .ds_rs_value   (ds_rs_value),
        .ds_rt_value   (ds_rt_value),
        .ds_imm        (ds_imm),
        .es_allowin    (es_allowin),
        .full          (full),
        .push          (push),
        .push_op       (push_op),
        .push_addr     (push_addr),
        .push_wdata    (push_wdata),
        .push_wstrb    (push_wstrb),
        .push_size     (push_size),
        .exc_valid     (exc_valid),
        .exc_code      (exc_code),
        .exc_bad_vaddr (exc_bad_vaddr)
    );

    mem_req_queue mem_req_queue_inst (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_op    (push_op),
        .push_addr  (push_addr),
        .push_wdata (push_wdata),
        .push_wstrb (push_wstrb),
        .push_size  (push_size),
        .pop        (pop),
        .full       (full),
        .empty      (empty),
        .head_op    (head_op),
        .head_addr  (head_addr),
        .head_wdata (head_wdata),
        .head_wstrb (head_wstrb),
        .head_size  (head_size)
    );

    mem_req_issuer mem_req_issuer_inst (
        .clk               (clk),
        .reset             (reset),
        .empty             (empty),
        .head_op           (head_op),
        .head_addr         (head_addr),
        .head_wdata        (head_wdata),
        .head_wstrb        (head_wstrb),
        .head_size         (head_size),
        .pop               (pop),
        .data_sram_en      (data_sram_en),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

endmodule

/* sim/exe_mem_properties.sv */
`timescale 1ns/1ps

module exe_mem_properties
    import mips_isa_pkg::*;
    import mem_bus_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  es_allowin,
    input logic  data_sram_en,
    input logic  data_sram_wr,
    input size_t data_sram_size,
    input strb_t data_sram_wstrb,
    input word_t data_sram_addr,
    input word_t data_sram_wdata,
    input logic  data_sram_addr_ok
);

    // request stays put until addr_ok
    request_held: assert property (
        @(posedge clk) disable iff (reset)
        data_sram_en && !data_sram_addr_ok |=>
            data_sram_en && $stable(data_sram_wr) && $stable(data_sram_size)
            && $stable(data_sram_wstrb) && $stable(data_sram_addr)
            && $stable(data_sram_wdata)
    ) else $error("SRAM request changed or dropped before addr_ok");

    // loads carry no strobes
    load_no_strobe: assert property (
        @(posedge clk) disable iff (reset)
        data_sram_en && !data_sram_wr |-> data_sram_wstrb == 4'b0000
    ) else $error("load request with nonzero wstrb");

    allowin_after_reset: assert property (
        @(posedge clk) $fell(reset) |-> es_allowin
    ) else $error("es_allowin low in the first cycle after reset");

endmodule

/* sim/tb_exe_mem.sv */
`timescale 1ns/1ps

module tb_exe_mem
    import mips_isa_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int NUM_INSTR   = 400;
    localparam int STALL_LIMIT = 200;
    localparam int DRAIN_LIMIT = 2000;

    logic      clk;
    logic      reset;
    logic      ds_valid;
    mem_op_t   ds_mem_op;
    word_t     ds_rs_value;
    word_t     ds_rt_value;
    imm_t      ds_imm;
    logic      es_allowin;
    logic      data_sram_en;
    logic      data_sram_wr;
    size_t     data_sram_size;
    strb_t     data_sram_wstrb;
    word_t     data_sram_addr;
    word_t     data_sram_wdata;
    logic      data_sram_addr_ok;
    logic      exc_valid;
    exc_code_t exc_code;
    word_t     exc_bad_vaddr;

    // {addr, wr, size, wstrb, wdata} and {code, bad vaddr}
    logic [70:0] exp_req_q [$];
    logic [36:0] exp_exc_q [$];

    integer seed;
    logic   take;
    logic   drained;
    logic   seen_accept;
    logic   ok_hold_low;
    int     ok_left;
    int     sent;
    int     stall;
    int     waited;

    exe_mem_top exe_mem_top_inst (.*);

    bind exe_mem_top exe_mem_properties exe_mem_properties_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run;
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: expected %h, actual %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    // expected outcome of one accepted instruction
    task automatic expect_instr(input mem_op_t op, input word_t rs, input word_t rt,
                                input imm_t imm);
        word_t addr;
        word_t data;
        strb_t strb;
        size_t size;
        logic  store;
        logic  bad;
        addr  = rs + {{16{imm[15]}}, imm};
        store = op inside {MEM_SB, MEM_SH, MEM_SW, MEM_SWL, MEM_SWR};
        size  = SIZE_WORD;
        bad   = 1'b0;
        data  = rt;
        strb  = 4'b0000;
        if (op inside {MEM_LB, MEM_LBU, MEM_SB}) begin
            size = SIZE_BYTE;
        end else if (op inside {MEM_LH, MEM_LHU, MEM_SH}) begin
            size = SIZE_HALF;
            bad  = addr[0];
        end else if (op inside {MEM_LW, MEM_SW}) begin
            bad = (addr[1:0] != 2'b00);
        end
        case (op)
            MEM_SB: begin
                data = {4{rt[7:0]}};
                strb = 4'b0001 << addr[1:0];
            end
            MEM_SH: begin
                data = {2{rt[15:0]}};
                strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: strb = 4'b1111;
            // bytes 0..k
            MEM_SWL: begin
                data = rt >> (8 * (3 - addr[1:0]));
                strb = 4'b1111 >> (3 - addr[1:0]);
            end
            // bytes k..3
            MEM_SWR: begin
                data = rt << (8 * addr[1:0]);
                strb = 4'b1111 << addr[1:0];
            end
            default: strb = 4'b0000;
        endcase
        if (bad) begin
            exp_exc_q.push_back({(store ? EXC_ADES : EXC_ADEL), addr});
        end else begin
            exp_req_q.push_back({addr, store, size, strb, data});
        end
    endtask

    task automatic check_request;
        logic [70:0] exp;
        if (exp_req_q.size() == 0) begin
            $display("SRAM request at %0t with no instruction waiting for one", $time);
            stop_run();
        end else begin
            exp = exp_req_q.pop_front();
            check_value("data_sram_addr", exp[70:39], data_sram_addr);
            check_value("data_sram_wr", exp[38], data_sram_wr);
            check_value("data_sram_size", exp[37:36], data_sram_size);
            check_value("data_sram_wstrb", exp[35:32], data_sram_wstrb);
            if (exp[38]) begin
                check_value("data_sram_wdata", exp[31:0], data_sram_wdata);
            end
        end
    endtask

    task automatic check_exception;
        logic [36:0] exp;
        if (exp_exc_q.size() == 0) begin
            $display("exception reported at %0t for an aligned instruction", $time);
            stop_run();
        end else begin
            exp = exp_exc_q.pop_front();
            check_value("exc_code", exp[36:32], exc_code);
            check_value("exc_bad_vaddr", exp[31:0], exc_bad_vaddr);
        end
    endtask

    // monitor and model, evaluated mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            // stage, queue and issuer hold at most QUEUE_DEPTH + 2 requests
            check_value("es_allowin", exp_req_q.size() < QUEUE_DEPTH + 2, es_allowin);
            if (!seen_accept) begin
                check_value("data_sram_en", 32'd0, data_sram_en);
                check_value("exc_valid", 32'd0, exc_valid);
            end
            if (exc_valid) begin
                check_exception();
            end
            if (data_sram_en && data_sram_addr_ok) begin
                check_request();
            end
            take = ds_valid && es_allowin;
            if (take) begin
                seen_accept = 1'b1;
                expect_instr(ds_mem_op, ds_rs_value, ds_rt_value, ds_imm);
            end
            drained = (exp_req_q.size() == 0) && (exp_exc_q.size() == 0) && !data_sram_en;
        end
    end

    // addr_ok in random phases with long low stretches
    task automatic drive_addr_ok;
        if (ok_left == 0) begin
            ok_hold_low = ($random(seed) & 3) == 0;
            ok_left = ok_hold_low ? 10 + {$random(seed)} % 31 : 5 + {$random(seed)} % 16;
        end
        ok_left = ok_left - 1;
        data_sram_addr_ok <= ok_hold_low ? 1'b0 : $random(seed) & 1;
    endtask

    task automatic new_instr;
        word_t rs;
        imm_t  imm;
        rs  = $random(seed);
        imm = imm_t'($random(seed));
        // half the addresses word aligned
        if ($random(seed) & 1) begin
            rs[1:0]  = 2'b00;
            imm[1:0] = 2'b00;
        end
        ds_valid    <= ($random(seed) & 3) != 0;
        ds_mem_op   <= mem_op_t'(4'({$random(seed)} % 10));
        ds_rs_value <= rs;
        ds_rt_value <= $random(seed);
        ds_imm      <= imm;
    endtask

    initial begin
        seed              = 32'h8019;
        reset             = 1'b1;
        ds_valid          = 1'b0;
        ds_mem_op         = MEM_LB;
        ds_rs_value       = '0;
        ds_rt_value       = '0;
        ds_imm            = '0;
        data_sram_addr_ok = 1'b0;
        take              = 1'b0;
        drained           = 1'b0;
        seen_accept       = 1'b0;
        ok_hold_low       = 1'b0;
        ok_left           = 0;
        sent              = 0;
        stall             = 0;
        waited            = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        while (sent < NUM_INSTR) begin
            @(posedge clk);
            drive_addr_ok();
            if (ds_valid && !take) begin
                stall = stall + 1;
                if (stall > STALL_LIMIT) begin
                    $display("instruction not accepted within %0d cycles", STALL_LIMIT);
                    stop_run();
                end
            end else begin
                stall = 0;
                if (take) begin
                    sent = sent + 1;
                end
                if (sent < NUM_INSTR) begin
                    new_instr();
                end else begin
                    ds_valid <= 1'b0;
                end
            end
        end
        while (!drained && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            drive_addr_ok();
            waited = waited + 1;
        end
        if (drained) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("%0d requests and %0d exceptions still pending after %0d cycles",
                     exp_req_q.size(), exp_exc_q.size(), DRAIN_LIMIT);
            stop_run();
        end
    end

endmodule

/* project.f */
logic/mips_isa_pkg.sv
logic/mem_bus_pkg.sv
logic/exe_addr_stage.sv
logic/mem_req_queue.sv
logic/mem_req_issuer.sv
logic/exe_mem_top.sv
sim/exe_mem_properties.sv
sim/tb_exe_mem.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := tb_exe_mem
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)
